// ==== common/hdc_macros.svh ====
`ifndef HDC_MACROS_SVH
`define HDC_MACROS_SVH

// ==================================================
// hypervector geometry
// ==================================================
// 32-bit words per hypervector
`define HV_WORDS 1
`define HV_W (`HV_WORDS * 32)
// item index and item counter
`define ITEM_W 16

// ==================================================
// control bus
// ==================================================
`define AXIL_DATA_W 32
// word-address field of the byte address
`define REG_ADDR_MSB 11
`define REG_ADDR_LSB 2
// register byte offsets
`define REG_CTRL 12'h000
`define REG_ITEM_NUM 12'h004
`define AXI_RESP_OKAY 2'b00

// prng start value after reseed
`define XORSHIFT_SEED 32'h92d68ca2

`endif

// ==== common/hdc_pkg.sv ====
`default_nettype none

`include "hdc_macros.svh"

package hdc_pkg;

    // register write request from the bus slave
    typedef struct packed {
        logic                                    valid;
        logic [`REG_ADDR_MSB-`REG_ADDR_LSB:0]    addr;
        logic [`AXIL_DATA_W-1:0]                 data;
    } reg_wr_t;

    // register read request, data comes back one cycle later
    typedef struct packed {
        logic                                    valid;
        logic [`REG_ADDR_MSB-`REG_ADDR_LSB:0]    addr;
    } reg_rd_t;

    // control register outputs
    typedef struct packed {
        logic                  run;
        logic                  gen;
        logic [`ITEM_W-1:0]    item_num;
    } ctrl_t;

    // generator completion report
    typedef struct packed {
        logic                  done;
        logic [`HV_W-1:0]      hv;
    } gen_done_t;

endpackage

`default_nettype wire

// ==== item_mem/xorshift32.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "hdc_macros.svh"

module xorshift32 (
    input  wire            AXIS_ACLK,
    input  wire            gen,
    output logic [31:0]    rand_num
);

    logic [31:0] state_q;
    logic [31:0] s1;
    logic [31:0] s2;

    // one xorshift step from the stored state
    always_comb begin
        s1       = state_q ^ (state_q << 13);
        s2       = s1 ^ (s1 >> 17);
        rand_num = s2 ^ (s2 << 5);
    end

    // idle keeps the seed, so each run starts at output 1
    always_ff @(posedge AXIS_ACLK) begin
        if (!gen) begin
            state_q <= `XORSHIFT_SEED;
        end else begin
            state_q <= rand_num;
        end
    end

endmodule

`default_nettype wire

// ==== hw/axil_slave.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "hdc_macros.svh"

module axil_slave import hdc_pkg::*; (
    input  wire                          AXIS_ACLK,
    input  wire                          S_AXI_ARESETN,
    // write address / data / response
    input  wire [31:0]                   S_AXI_AWADDR,
    input  wire                          S_AXI_AWVALID,
    output logic                         S_AXI_AWREADY,
    input  wire [`AXIL_DATA_W-1:0]       S_AXI_WDATA,
    input  wire                          S_AXI_WVALID,
    output logic                         S_AXI_WREADY,
    output logic [1:0]                   S_AXI_BRESP,
    output logic                         S_AXI_BVALID,
    input  wire                          S_AXI_BREADY,
    // read address / data
    input  wire [31:0]                   S_AXI_ARADDR,
    input  wire                          S_AXI_ARVALID,
    output logic                         S_AXI_ARREADY,
    output logic [`AXIL_DATA_W-1:0]      S_AXI_RDATA,
    output logic [1:0]                   S_AXI_RRESP,
    output logic                         S_AXI_RVALID,
    input  wire                          S_AXI_RREADY,
    // register bank side
    input  wire [`AXIL_DATA_W-1:0]       rdata,
    output reg_wr_t                      reg_wr,
    output reg_rd_t                      reg_rd
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_AW,
        ST_W,
        ST_RESP,
        ST_AR1,
        ST_AR2
    } state_t;

    state_t state;
    state_t state_nxt;

    logic [`REG_ADDR_MSB-`REG_ADDR_LSB:0] wr_addr;
    logic [`REG_ADDR_MSB-`REG_ADDR_LSB:0] rd_addr;
    logic [`AXIL_DATA_W-1:0]              wr_data;
    logic                                 wr_pulse;

    // ==================================================
    // handshake outputs
    // ==================================================
    assign S_AXI_AWREADY = (state == ST_IDLE) || (state == ST_W);
    assign S_AXI_WREADY  = (state == ST_IDLE) || (state == ST_AW);
    // reads wait while a write is offered in idle
    assign S_AXI_ARREADY = (state == ST_IDLE) && !S_AXI_AWVALID && !S_AXI_WVALID;
    assign S_AXI_BVALID  = (state == ST_RESP);
    assign S_AXI_RVALID  = (state == ST_AR2);
    assign S_AXI_BRESP   = `AXI_RESP_OKAY;
    assign S_AXI_RRESP   = `AXI_RESP_OKAY;
    // register bank already holds read data
    assign S_AXI_RDATA   = rdata;

    // ==================================================
    // next state
    // ==================================================
    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE: begin
                // writes first, both halves together go straight to response
                if (S_AXI_AWVALID && S_AXI_WVALID) begin
                    state_nxt = ST_RESP;
                end else if (S_AXI_AWVALID) begin
                    state_nxt = ST_AW;
                end else if (S_AXI_WVALID) begin
                    state_nxt = ST_W;
                end else if (S_AXI_ARVALID) begin
                    state_nxt = ST_AR1;
                end
            end
            // address held, waiting for data
            ST_AW: begin
                if (S_AXI_WVALID) begin
                    state_nxt = ST_RESP;
                end
            end
            // data held, waiting for address
            ST_W: begin
                if (S_AXI_AWVALID) begin
                    state_nxt = ST_RESP;
                end
            end
            ST_RESP: begin
                if (S_AXI_BREADY) begin
                    state_nxt = ST_IDLE;
                end
            end
            // single cycle, register bank samples the read here
            ST_AR1: begin
                state_nxt = ST_AR2;
            end
            ST_AR2: begin
                if (S_AXI_RREADY) begin
                    state_nxt = ST_IDLE;
                end
            end
            default: begin
                state_nxt = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN) begin
            state    <= ST_IDLE;
            wr_pulse <= 1'b0;
        end else begin
            state    <= state_nxt;
            // one pulse on entry to the response state
            wr_pulse <= (state != ST_RESP) && (state_nxt == ST_RESP);
        end
    end

    // address and data capture on each accepted beat
    always_ff @(posedge AXIS_ACLK) begin
        if (S_AXI_AWVALID && S_AXI_AWREADY) begin
            wr_addr <= S_AXI_AWADDR[`REG_ADDR_MSB:`REG_ADDR_LSB];
        end
        if (S_AXI_WVALID && S_AXI_WREADY) begin
            wr_data <= S_AXI_WDATA;
        end
        if (S_AXI_ARVALID && S_AXI_ARREADY) begin
            rd_addr <= S_AXI_ARADDR[`REG_ADDR_MSB:`REG_ADDR_LSB];
        end
    end

    assign reg_wr = '{valid: wr_pulse, addr: wr_addr, data: wr_data};
    assign reg_rd = '{valid: (state == ST_AR1), addr: rd_addr};

    // responses must not drop before the master takes them
    a_bvalid_hold: assert property (@(posedge AXIS_ACLK) disable iff (!S_AXI_ARESETN)
        S_AXI_BVALID && !S_AXI_BREADY |=> S_AXI_BVALID);
    a_rvalid_hold: assert property (@(posedge AXIS_ACLK) disable iff (!S_AXI_ARESETN)
        S_AXI_RVALID && !S_AXI_RREADY |=> S_AXI_RVALID && $stable(S_AXI_RDATA));

endmodule

`default_nettype wire

// ==== hw/ctrl_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "hdc_macros.svh"

module ctrl_regs import hdc_pkg::*; (
    input  wire                          AXIS_ACLK,
    input  wire                          S_AXI_ARESETN,
    input  wire reg_wr_t                 reg_wr,
    input  wire reg_rd_t                 reg_rd,
    input  wire gen_done_t               gen_done,
    output ctrl_t                        ctrl,
    output logic [`AXIL_DATA_W-1:0]      rdata
);

    ctrl_t       ctrl_q;
    logic [11:0] wr_byte;
    logic [11:0] rd_byte;
    logic        wr_hit;
    logic        rd_hit;

    // back to byte offsets, bits 11:10 select the register region
    assign wr_byte = {reg_wr.addr, 2'b00};
    assign rd_byte = {reg_rd.addr, 2'b00};
    assign wr_hit  = reg_wr.valid && (wr_byte[11:10] == 2'b00);
    assign rd_hit  = (rd_byte[11:10] == 2'b00);

    // ==================================================
    // register write
    // ==================================================
    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN) begin
            ctrl_q <= '0;
        end else begin
            // generator finished its item
            if (gen_done.done) begin
                ctrl_q.gen <= 1'b0;
            end
            // host write overrides the clear
            if (wr_hit && (wr_byte == `REG_CTRL)) begin
                ctrl_q.run <= reg_wr.data[1];
                ctrl_q.gen <= reg_wr.data[0];
            end
            if (wr_hit && (wr_byte == `REG_ITEM_NUM)) begin
                ctrl_q.item_num <= reg_wr.data[`ITEM_W-1:0];
            end
        end
    end

    assign ctrl = ctrl_q;

    // ==================================================
    // register read
    // ==================================================
    always_ff @(posedge AXIS_ACLK) begin
        if (reg_rd.valid) begin
            rdata <= '0;
            // other regions read zero
            if (rd_hit) begin
                case (rd_byte)
                    `REG_CTRL:
                        rdata <= `AXIL_DATA_W'({ctrl_q.run, ctrl_q.gen});
                    `REG_ITEM_NUM:
                        rdata <= `AXIL_DATA_W'(ctrl_q.item_num);
                    default: ;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// ==== item_mem/item_memory_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "hdc_macros.svh"

module item_memory_gen import hdc_pkg::*; (
    input  wire              AXIS_ACLK,
    input  wire              S_AXI_ARESETN,
    input  wire ctrl_t       ctrl,
    output gen_done_t        gen_done
);

    // word counter needs at least one bit
    localparam int WORD_CW = (`HV_WORDS > 1) ? $clog2(`HV_WORDS) : 1;

    logic [WORD_CW-1:0]  word_cnt;
    logic [`ITEM_W-1:0]  item_cnt;
    logic [31:0]         rand_num;
    logic [`HV_W-1:0]    hv_asm;
    logic [`HV_W-1:0]    hv_next;
    logic [`HV_W-1:0]    hv_cap;
    logic                last_word;
    logic                done_q;

    // prng runs only while generating, reseeds otherwise
    xorshift32 i_xorshift32 (
        .AXIS_ACLK (AXIS_ACLK),
        .gen       (ctrl.gen),
        .rand_num  (rand_num)
    );

    assign last_word = (word_cnt == WORD_CW'(`HV_WORDS - 1));

    // vector with the current prng word dropped into its slot
    always_comb begin
        hv_next = hv_asm;
        hv_next[word_cnt*32 +: 32] = rand_num;
    end

    // ==================================================
    // word and item counters
    // ==================================================
    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN || !ctrl.gen) begin
            word_cnt <= '0;
            item_cnt <= '0;
            done_q   <= 1'b0;
        end else begin
            done_q <= 1'b0;
            if (last_word) begin
                word_cnt <= '0;
                item_cnt <= item_cnt + 1'b1;
                // completed item is the requested one
                if (item_cnt == ctrl.item_num) begin
                    done_q <= 1'b1;
                end
            end else begin
                word_cnt <= word_cnt + 1'b1;
            end
        end
    end

    // vector assembly and capture
    always_ff @(posedge AXIS_ACLK) begin
        if (ctrl.gen) begin
            hv_asm <= hv_next;
            if (last_word && (item_cnt == ctrl.item_num)) begin
                hv_cap <= hv_next;
            end
        end
    end

    assign gen_done = '{done: done_q, hv: hv_cap};

    // gen is cleared by the done pulse, so done never stretches
    a_done_pulse: assert property (@(posedge AXIS_ACLK) disable iff (!S_AXI_ARESETN)
        gen_done.done |=> !gen_done.done);

endmodule

`default_nettype wire

// ==== hw/hv_stream_out.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "hdc_macros.svh"

module hv_stream_out import hdc_pkg::*; (
    input  wire                   AXIS_ACLK,
    input  wire                   S_AXI_ARESETN,
    input  wire ctrl_t            ctrl,
    input  wire gen_done_t        gen_done,
    input  wire                   tready,
    output logic                  tvalid,
    output logic [`HV_W-1:0]      tdata,
    output logic                  tlast,
    output logic [7:0]            tstrb
);

    // beat valid, cleared by acceptance or by run going low
    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN || !ctrl.run) begin
            tvalid <= 1'b0;
        end else if (tvalid) begin
            if (tready) begin
                tvalid <= 1'b0;
            end
        end else if (gen_done.done) begin
            tvalid <= 1'b1;
        end
    end

    // load only into an empty slot, pending beat keeps its data
    always_ff @(posedge AXIS_ACLK) begin
        if (ctrl.run && !tvalid && gen_done.done) begin
            tdata <= gen_done.hv;
        end
    end

    // whole vector in one beat
    assign tlast = tvalid;
    assign tstrb = 8'hff;

    a_tdata_stable: assert property (@(posedge AXIS_ACLK) disable iff (!S_AXI_ARESETN)
        tvalid && !tready |=> $stable(tdata));

endmodule

`default_nettype wire

// ==== hw/hdc_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "hdc_macros.svh"

module hdc_top import hdc_pkg::*; (
    input  wire                          AXIS_ACLK,
    input  wire                          S_AXI_ARESETN,
    // axi4-lite control
    input  wire [31:0]                   S_AXI_AWADDR,
    input  wire                          S_AXI_AWVALID,
    output logic                         S_AXI_AWREADY,
    input  wire [`AXIL_DATA_W-1:0]       S_AXI_WDATA,
    input  wire                          S_AXI_WVALID,
    output logic                         S_AXI_WREADY,
    output logic [1:0]                   S_AXI_BRESP,
    output logic                         S_AXI_BVALID,
    input  wire                          S_AXI_BREADY,
    input  wire [31:0]                   S_AXI_ARADDR,
    input  wire                          S_AXI_ARVALID,
    output logic                         S_AXI_ARREADY,
    output logic [`AXIL_DATA_W-1:0]      S_AXI_RDATA,
    output logic [1:0]                   S_AXI_RRESP,
    output logic                         S_AXI_RVALID,
    input  wire                          S_AXI_RREADY,
    // axi4-stream hypervector out
    output logic                         M_AXIS_TVALID,
    output logic [`HV_W-1:0]             M_AXIS_TDATA,
    output logic [7:0]                   M_AXIS_TSTRB,
    output logic                         M_AXIS_TLAST,
    input  wire                          M_AXIS_TREADY
);

    reg_wr_t                  reg_wr;
    reg_rd_t                  reg_rd;
    logic [`AXIL_DATA_W-1:0]  rdata;
    ctrl_t                    ctrl;
    gen_done_t                gen_done;

    // ==================================================
    // control path
    // ==================================================
    axil_slave i_axil_slave (
        .AXIS_ACLK     (AXIS_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .S_AXI_AWADDR  (S_AXI_AWADDR),
        .S_AXI_AWVALID (S_AXI_AWVALID),
        .S_AXI_AWREADY (S_AXI_AWREADY),
        .S_AXI_WDATA   (S_AXI_WDATA),
        .S_AXI_WVALID  (S_AXI_WVALID),
        .S_AXI_WREADY  (S_AXI_WREADY),
        .S_AXI_BRESP   (S_AXI_BRESP),
        .S_AXI_BVALID  (S_AXI_BVALID),
        .S_AXI_BREADY  (S_AXI_BREADY),
        .S_AXI_ARADDR  (S_AXI_ARADDR),
        .S_AXI_ARVALID (S_AXI_ARVALID),
        .S_AXI_ARREADY (S_AXI_ARREADY),
        .S_AXI_RDATA   (S_AXI_RDATA),
        .S_AXI_RRESP   (S_AXI_RRESP),
        .S_AXI_RVALID  (S_AXI_RVALID),
        .S_AXI_RREADY  (S_AXI_RREADY),
        .rdata         (rdata),
        .reg_wr        (reg_wr),
        .reg_rd        (reg_rd)
    );

    ctrl_regs i_ctrl_regs (
        .AXIS_ACLK     (AXIS_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .reg_wr        (reg_wr),
        .reg_rd        (reg_rd),
        .gen_done      (gen_done),
        .ctrl          (ctrl),
        .rdata         (rdata)
    );

    // ==================================================
    // generation and stream out
    // ==================================================
    item_memory_gen i_item_memory_gen (
        .AXIS_ACLK     (AXIS_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .ctrl          (ctrl),
        .gen_done      (gen_done)
    );

    hv_stream_out i_hv_stream_out (
        .AXIS_ACLK     (AXIS_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .ctrl          (ctrl),
        .gen_done      (gen_done),
        .tready        (M_AXIS_TREADY),
        .tvalid        (M_AXIS_TVALID),
        .tdata         (M_AXIS_TDATA),
        .tlast         (M_AXIS_TLAST),
        .tstrb         (M_AXIS_TSTRB)
    );

endmodule

`default_nettype wire

// ==== tb/tb_hdc_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "hdc_macros.svh"

module tb_hdc_top;

    // check width covers both register words and whole vectors
    localparam int CHK_W = (`HV_W > 32) ? `HV_W : 32;
    localparam int MAX_ITEMS = 64;
    // rough run length is 8 generation runs of up to 64 items plus ~60 bus ops of ~12 cycles
    localparam int GEN_RUNS = 8;
    localparam int BUS_OPS = 60;
    localparam int EST_CYCLES = GEN_RUNS * MAX_ITEMS * `HV_WORDS + BUS_OPS * 12;
    localparam int CYCLE_LIMIT = (EST_CYCLES * 10 > 20000) ? EST_CYCLES * 10 : 20000;

    logic                     AXIS_ACLK;
    logic                     S_AXI_ARESETN;
    // axi4-lite master side
    logic [31:0]              awaddr;
    logic                     awvalid;
    logic                     awready;
    logic [31:0]              wdata;
    logic                     wvalid;
    logic                     wready;
    logic [1:0]               bresp;
    logic                     bvalid;
    logic                     bready;
    logic [31:0]              araddr;
    logic                     arvalid;
    logic                     arready;
    logic [31:0]              rdata;
    logic [1:0]               rresp;
    logic                     rvalid;
    logic                     rready;
    // axi4-stream sink side
    logic                     tvalid;
    logic [`HV_W-1:0]         tdata;
    logic [7:0]               tstrb;
    logic                     tlast;
    logic                     tready;

    integer                   seed;
    int                       cycles;
    int                       err_total;
    int                       test_errs;
    int                       pass_cnt;
    int                       fail_cnt;
    string                    test_name;
    // flags any beat while run is low
    logic                     watch_no_beat;
    logic                     saw_beat;

    always #50 AXIS_ACLK = ~AXIS_ACLK;

    hdc_top i_hdc_top (
        .AXIS_ACLK     (AXIS_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .S_AXI_AWADDR  (awaddr),
        .S_AXI_AWVALID (awvalid),
        .S_AXI_AWREADY (awready),
        .S_AXI_WDATA   (wdata),
        .S_AXI_WVALID  (wvalid),
        .S_AXI_WREADY  (wready),
        .S_AXI_BRESP   (bresp),
        .S_AXI_BVALID  (bvalid),
        .S_AXI_BREADY  (bready),
        .S_AXI_ARADDR  (araddr),
        .S_AXI_ARVALID (arvalid),
        .S_AXI_ARREADY (arready),
        .S_AXI_RDATA   (rdata),
        .S_AXI_RRESP   (rresp),
        .S_AXI_RVALID  (rvalid),
        .S_AXI_RREADY  (rready),
        .M_AXIS_TVALID (tvalid),
        .M_AXIS_TDATA  (tdata),
        .M_AXIS_TSTRB  (tstrb),
        .M_AXIS_TLAST  (tlast),
        .M_AXIS_TREADY (tready)
    );

    // ==================================================
    // watchdog and stream monitor
    // ==================================================
    always @(posedge AXIS_ACLK) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: DUT gave no response within %0d cycles", CYCLE_LIMIT);
            $display("=== FAIL ===");
            $finish;
        end
    end

    always @(negedge AXIS_ACLK) begin
        if (watch_no_beat && tvalid) begin
            saw_beat <= 1'b1;
        end
    end

    // ==================================================
    // reference model
    // ==================================================
    // shifts 13 left then 17 right then 5 left with each xored in
    function automatic logic [31:0] next_xorshift(input logic [31:0] x);
        logic [31:0] s;
        s = x ^ (x << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // item k holds outputs k*HV_WORDS+1 .. (k+1)*HV_WORDS with word j at bits 32j+31:32j
    function automatic logic [`HV_W-1:0] model_item(input int k);
        logic [31:0]      s;
        logic [`HV_W-1:0] hv;
        int               n;
        s  = `XORSHIFT_SEED;
        hv = '0;
        for (n = 1; n <= (k + 1) * `HV_WORDS; n++) begin
            s = next_xorshift(s);
            if (n > k * `HV_WORDS) begin
                hv[(n - k * `HV_WORDS - 1) * 32 +: 32] = s;
            end
        end
        return hv;
    endfunction

    // ==================================================
    // check and bookkeeping
    // ==================================================
    task automatic check_value(input string what, input logic [CHK_W-1:0] exp,
                               input logic [CHK_W-1:0] act);
        if (exp !== act) begin
            $display("Error: %s %s expected %h actual %h", test_name, what, exp, act);
            test_errs++;
            err_total++;
        end
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_errs = 0;
    endtask

    task automatic report_test;
        if (test_errs == 0) begin
            pass_cnt++;
            $display("%s: passed", test_name);
        end else begin
            fail_cnt++;
            $display("%s: failed with %0d errors", test_name, test_errs);
        end
    endtask

    // ==================================================
    // bus helpers
    // ==================================================
    // split presents aw first and w only after aw is taken
    task automatic write_reg(input logic [31:0] addr, input logic [31:0] data,
                             input bit split);
        @(negedge AXIS_ACLK);
        awaddr = addr;
        wdata  = data;
        if (split) begin
            awvalid = 1'b1;
            while (!awready) @(negedge AXIS_ACLK);
            @(negedge AXIS_ACLK);
            awvalid = 1'b0;
            // address held so only the data channel stays open
            check_value("awready with address held", 1'b0, awready);
            check_value("wready with address held", 1'b1, wready);
            wvalid  = 1'b1;
            while (!wready) @(negedge AXIS_ACLK);
            @(negedge AXIS_ACLK);
            wvalid = 1'b0;
        end else begin
            awvalid = 1'b1;
            wvalid  = 1'b1;
            while (!(awready && wready)) @(negedge AXIS_ACLK);
            @(negedge AXIS_ACLK);
            awvalid = 1'b0;
            wvalid  = 1'b0;
            // response pending so every request channel is closed
            check_value("awready in response", 1'b0, awready);
            check_value("wready in response", 1'b0, wready);
            check_value("arready in response", 1'b0, arready);
        end
        bready = 1'b1;
        while (!bvalid) @(negedge AXIS_ACLK);
        check_value("bresp", `AXI_RESP_OKAY, bresp);
        @(negedge AXIS_ACLK);
        bready = 1'b0;
    endtask

    task automatic read_reg(input logic [31:0] addr, output logic [31:0] data);
        @(negedge AXIS_ACLK);
        araddr  = addr;
        arvalid = 1'b1;
        while (!arready) @(negedge AXIS_ACLK);
        @(negedge AXIS_ACLK);
        arvalid = 1'b0;
        rready  = 1'b1;
        while (!rvalid) @(negedge AXIS_ACLK);
        data = rdata;
        check_value("rresp", `AXI_RESP_OKAY, rresp);
        @(negedge AXIS_ACLK);
        rready = 1'b0;
    endtask

    // waits for a beat, stalls it for hold cycles, then takes it
    task automatic wait_stream(input int hold, output logic [`HV_W-1:0] data,
                               output logic last, output logic [7:0] strb);
        while (!tvalid) @(negedge AXIS_ACLK);
        data = tdata;
        last = tlast;
        strb = tstrb;
        repeat (hold) begin
            @(negedge AXIS_ACLK);
            check_value("tvalid held", 1'b1, tvalid);
            check_value("tdata held", data, tdata);
        end
        tready = 1'b1;
        @(negedge AXIS_ACLK);
        tready = 1'b0;
        check_value("tvalid after accept", 1'b0, tvalid);
    endtask

    // ==================================================
    // directed tests
    // ==================================================
    task automatic reset_values;
        logic [31:0] rd;
        start_test("reset_values");
        read_reg(`REG_CTRL, rd);
        check_value("ctrl", 32'h0, rd);
        read_reg(`REG_ITEM_NUM, rd);
        check_value("item_num", 32'h0, rd);
        check_value("tvalid", 1'b0, tvalid);
        report_test;
    endtask

    task automatic register_access;
        logic [31:0] rd;
        start_test("register_access");
        // item_num keeps 16 bits so the upper half reads zero
        write_reg(`REG_ITEM_NUM, 32'hdead_a5c3, 1'b0);
        read_reg(`REG_ITEM_NUM, rd);
        check_value("item_num", 32'h0000_a5c3, rd);
        // run alone starts nothing
        write_reg(`REG_CTRL, 32'h2, 1'b0);
        read_reg(`REG_CTRL, rd);
        check_value("ctrl run", 32'h2, rd);
        write_reg(`REG_CTRL, 32'h0, 1'b0);
        read_reg(`REG_CTRL, rd);
        check_value("ctrl", 32'h0, rd);
        // region 1 aliases the register word offsets and must not reach them
        write_reg(32'h400, 32'h3, 1'b1);
        read_reg(32'h404, rd);
        check_value("region 1 read", 32'h0, rd);
        read_reg(`REG_CTRL, rd);
        check_value("ctrl after region 1 write", 32'h0, rd);
        write_reg(32'h404, 32'h7777, 1'b0);
        read_reg(`REG_ITEM_NUM, rd);
        check_value("item_num after region 1 write", 32'h0000_a5c3, rd);
        // aw then w in separate cycles
        write_reg(`REG_ITEM_NUM, 32'h11, 1'b1);
        read_reg(`REG_ITEM_NUM, rd);
        check_value("item_num split write", 32'h11, rd);
        check_value("tvalid", 1'b0, tvalid);
        report_test;
    endtask

    task automatic capture_item0;
        logic [31:0]      rd;
        logic [`HV_W-1:0] hv;
        logic             last;
        logic [7:0]       strb;
        start_test("capture_item0");
        write_reg(`REG_ITEM_NUM, 32'h0, 1'b0);
        write_reg(`REG_CTRL, 32'h3, 1'b0);
        wait_stream(0, hv, last, strb);
        check_value("tdata", model_item(0), hv);
        check_value("tlast", 1'b1, last);
        check_value("tstrb", 8'hff, strb);
        // run stays set while done clears gen
        read_reg(`REG_CTRL, rd);
        check_value("ctrl after done", 32'h2, rd);
        report_test;
    endtask

    task automatic capture_random_items;
        logic [31:0]      rd;
        logic [`HV_W-1:0] hv;
        logic             last;
        logic [7:0]       strb;
        int               k;
        int               i;
        start_test("capture_random_items");
        for (i = 0; i < 5; i++) begin
            k = $unsigned($random(seed)) % MAX_ITEMS;
            write_reg(`REG_ITEM_NUM, k, 1'b0);
            write_reg(`REG_CTRL, 32'h3, 1'b0);
            wait_stream(0, hv, last, strb);
            check_value($sformatf("tdata item %0d", k), model_item(k), hv);
            check_value("tlast", 1'b1, last);
            read_reg(`REG_CTRL, rd);
            check_value("ctrl after done", 32'h2, rd);
        end
        report_test;
    endtask

    task automatic stream_backpressure;
        logic [31:0]      rd;
        logic [`HV_W-1:0] hv;
        logic             last;
        logic [7:0]       strb;
        start_test("stream_backpressure");
        write_reg(`REG_ITEM_NUM, 32'h2, 1'b0);
        write_reg(`REG_CTRL, 32'h3, 1'b0);
        // tready low for 12 cycles while the beat waits
        wait_stream(12, hv, last, strb);
        check_value("tdata item 2", model_item(2), hv);
        // generate with run low and expect no beat
        write_reg(`REG_CTRL, 32'h0, 1'b0);
        write_reg(`REG_ITEM_NUM, 32'h5, 1'b0);
        saw_beat      = 1'b0;
        watch_no_beat = 1'b1;
        write_reg(`REG_CTRL, 32'h1, 1'b0);
        read_reg(`REG_CTRL, rd);
        while (rd[0]) begin
            read_reg(`REG_CTRL, rd);
        end
        check_value("ctrl after done", 32'h0, rd);
        repeat (4) @(negedge AXIS_ACLK);
        watch_no_beat = 1'b0;
        check_value("beat with run low", 1'b0, saw_beat);
        report_test;
    endtask

    // ==================================================
    // main sequence
    // ==================================================
    initial begin
        AXIS_ACLK     = 1'b0;
        S_AXI_ARESETN = 1'b0;
        awaddr        = '0;
        awvalid       = 1'b0;
        wdata         = '0;
        wvalid        = 1'b0;
        bready        = 1'b0;
        araddr        = '0;
        arvalid       = 1'b0;
        rready        = 1'b0;
        tready        = 1'b0;
        seed          = 32'he342;
        cycles        = 0;
        err_total     = 0;
        pass_cnt      = 0;
        fail_cnt      = 0;
        watch_no_beat = 1'b0;
        saw_beat      = 1'b0;
        repeat (4) @(negedge AXIS_ACLK);
        S_AXI_ARESETN = 1'b1;

        reset_values;
        register_access;
        capture_item0;
        capture_random_items;
        stream_backpressure;

        $display("tests passed %0d failed %0d errors %0d", pass_cnt, fail_cnt, err_total);
        if (fail_cnt == 0 && err_total == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+common
common/hdc_pkg.sv
item_mem/xorshift32.sv
hw/axil_slave.sv
hw/ctrl_regs.sv
item_mem/item_memory_gen.sv
hw/hv_stream_out.sv
hw/hdc_top.sv
tb/tb_hdc_top.sv

// ==== Bender.yml ====
package:
  name: hdc_top

sources:
  - include_dirs:
      - common
    files:
      - common/hdc_pkg.sv
      - item_mem/xorshift32.sv
      - hw/axil_slave.sv
      - hw/ctrl_regs.sv
      - item_mem/item_memory_gen.sv
      - hw/hv_stream_out.sv
      - hw/hdc_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - tb/tb_hdc_top.sv
